// ==== rtl/sd_bus_pkg.sv ====
// host slave register map: four 32-bit words, word addressed, no burst support
package sd_bus_pkg;

	// bus geometry
	localparam int BUS_DATA_W = 32;
	localparam int BUS_ADDR_W = 2;

	// word addresses
	localparam logic [BUS_ADDR_W-1:0] REG_ARG    = 2'd0;
	localparam logic [BUS_ADDR_W-1:0] REG_CMD    = 2'd1;
	localparam logic [BUS_ADDR_W-1:0] REG_STATUS = 2'd2;
	localparam logic [BUS_ADDR_W-1:0] REG_REPLY  = 2'd3;

	// command word: index in byte 0, reply kind in byte 1
	localparam int CMD_INDEX_LSB = 0;
	localparam int CMD_KIND_LSB  = 8;

	// status word fields
	localparam int STAT_BUSY_BIT  = 0;
	localparam int STAT_ERR_LSB   = 1;
	localparam int STAT_INDEX_LSB = 8;

endpackage

// ==== rtl/sd_clk_gen.sv ====
// card clock is CLK_I/4, registered one cycle after phase 1; stopped low while disabled
`timescale 1ns/1ps

module sd_clk_gen (
	input  logic CLK_I,
	input  logic RST_I,
	input  logic clk_ena_i,
	output logic sd_clk_o,
	output logic bit_tick_o
);

	logic [1:0] phase;

	always_ff @(posedge CLK_I) begin
		if (RST_I) begin
			phase <= 2'd0;
			sd_clk_o <= 1'b0;
		end else begin
			// park at 0 so the first tick comes right after enable
			if (clk_ena_i)
				phase <= phase + 2'd1;
			else
				phase <= 2'd0;
			sd_clk_o <= clk_ena_i && (phase == 2'd1);
		end
	end

	// engine slot, card clock is low here
	assign bit_tick_o = (phase == 2'd0);

endmodule

// ==== rtl/sd_cmd_engine.sv ====
// one command at a time; starts while busy are dropped, R2 and busy waits not handled
`timescale 1ns/1ps

module sd_cmd_engine (
	input  logic                                 CLK_I,
	input  logic                                 RST_I,
	input  logic                                 start_i,
	input  logic [sd_proto_pkg::CMD_INDEX_W-1:0] cmd_index_i,
	input  logic [sd_proto_pkg::CMD_ARG_W-1:0]   cmd_arg_i,
	input  logic [1:0]                           reply_kind_i,
	input  logic                                 bit_tick_i,
	input  logic                                 cmd_in_i,
	output logic                                 cmd_out_o,
	output logic                                 cmd_oe_o,
	output logic                                 clk_ena_o,
	output logic                                 busy_o,
	output logic [1:0]                           err_code_o,
	output sd_proto_pkg::sd_reply_t              reply_o
);
	import sd_proto_pkg::*;

	// index plus argument, and the reply bits between start bit and CRC
	localparam int BODY_W   = CMD_FRAME_W - CRC7_W - 3;
	localparam int RSP_BODY = CMD_FRAME_W - CRC7_W - 2;

	localparam logic [3:0] S_IDLE        = 4'd0;
	localparam logic [3:0] S_PREAMBLE    = 4'd1;
	localparam logic [3:0] S_START       = 4'd2;
	localparam logic [3:0] S_HOST        = 4'd3;
	localparam logic [3:0] S_BODY        = 4'd4;
	localparam logic [3:0] S_CRC         = 4'd5;
	localparam logic [3:0] S_END         = 4'd6;
	localparam logic [3:0] S_POST        = 4'd7;
	localparam logic [3:0] S_RSP_START   = 4'd8;
	localparam logic [3:0] S_RSP_BODY    = 4'd9;
	localparam logic [3:0] S_RSP_CRC_END = 4'd10;

	logic [3:0]             state;
	logic [7:0]             bit_cnt;
	logic [1:0]             kind_q;
	logic [BODY_W-1:0]      send_sr;
	logic [CRC7_W-1:0]      crc;
	logic [CMD_FRAME_W-1:0] rx_q;
	sd_reply_t              rx_next;

	// x^7 + x^3 + 1, message MSB first
	function automatic logic [CRC7_W-1:0] crc7_next(input logic [CRC7_W-1:0] c, input logic din);
		logic fb;
		fb = din ^ c[CRC7_W-1];
		crc7_next = {c[CRC7_W-2:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
	endfunction

	assign rx_next = {rx_q[CMD_FRAME_W-2:0], cmd_in_i};
	assign reply_o = rx_q;

	always_ff @(posedge CLK_I) begin
		if (RST_I) begin
			state <= S_IDLE;
			bit_cnt <= 8'd0;
			kind_q <= REPLY_KIND_NONE;
			cmd_out_o <= 1'b1;
			cmd_oe_o <= 1'b0;
			clk_ena_o <= 1'b0;
			busy_o <= 1'b0;
			err_code_o <= ERR_NONE;
			rx_q <= '0;
		end else if (state == S_IDLE) begin
			if (start_i) begin
				state <= S_PREAMBLE;
				bit_cnt <= 8'd0;
				kind_q <= reply_kind_i;
				clk_ena_o <= 1'b1;
				busy_o <= 1'b1;
				err_code_o <= ERR_NONE;
				rx_q <= '0;
			end
		end else if (bit_tick_i) begin
			case (state)
				S_PREAMBLE: begin
					cmd_oe_o <= 1'b1;
					cmd_out_o <= 1'b1;
					bit_cnt <= bit_cnt + 8'd1;
					if (bit_cnt == 8'(PREAMBLE_BITS - 1)) begin
						state <= S_START;
						bit_cnt <= 8'd0;
					end
				end
				S_START: begin
					cmd_out_o <= 1'b0;
					state <= S_HOST;
				end
				S_HOST: begin
					cmd_out_o <= 1'b1;
					state <= S_BODY;
				end
				S_BODY: begin
					cmd_out_o <= send_sr[BODY_W-1];
					bit_cnt <= bit_cnt + 8'd1;
					if (bit_cnt == 8'(BODY_W - 1)) begin
						state <= S_CRC;
						bit_cnt <= 8'd0;
					end
				end
				S_CRC: begin
					cmd_out_o <= crc[CRC7_W-1];
					bit_cnt <= bit_cnt + 8'd1;
					if (bit_cnt == 8'(CRC7_W - 1)) begin
						state <= S_END;
						bit_cnt <= 8'd0;
					end
				end
				S_END: begin
					cmd_out_o <= 1'b1;
					state <= (kind_q == REPLY_KIND_NONE) ? S_POST : S_RSP_START;
				end
				S_RSP_START: begin
					// first slot still sees our own end bit
					cmd_oe_o <= 1'b0;
					bit_cnt <= bit_cnt + 8'd1;
					if (!cmd_in_i) begin
						rx_q <= rx_next;
						state <= S_RSP_BODY;
						bit_cnt <= 8'd0;
					end else if (bit_cnt == 8'(REPLY_TIMEOUT)) begin
						err_code_o <= ERR_TIMEOUT;
						state <= S_IDLE;
						bit_cnt <= 8'd0;
						clk_ena_o <= 1'b0;
						busy_o <= 1'b0;
					end
				end
				S_RSP_BODY: begin
					rx_q <= rx_next;
					bit_cnt <= bit_cnt + 8'd1;
					if (bit_cnt == 8'(RSP_BODY - 1)) begin
						state <= S_RSP_CRC_END;
						bit_cnt <= 8'd0;
					end
				end
				S_RSP_CRC_END: begin
					rx_q <= rx_next;
					bit_cnt <= bit_cnt + 8'd1;
					if (bit_cnt == 8'(CRC7_W)) begin
						if (!rx_next.r1.end_bit)
							err_code_o <= ERR_END_BIT;
						else if (kind_q == REPLY_KIND_R1 && rx_next.r1.crc != crc)
							err_code_o <= ERR_CRC;
						else
							err_code_o <= ERR_NONE;
						state <= S_POST;
						bit_cnt <= 8'd0;
					end
				end
				S_POST: begin
					// line keeps its drive state, ones for NONE, released after a reply
					bit_cnt <= bit_cnt + 8'd1;
					if (bit_cnt == 8'(POSTAMBLE_BITS)) begin
						state <= S_IDLE;
						bit_cnt <= 8'd0;
						cmd_oe_o <= 1'b0;
						clk_ena_o <= 1'b0;
						busy_o <= 1'b0;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// shared CRC7, reloaded on start, zero again after the sent CRC shifts out
	always_ff @(posedge CLK_I) begin
		if (state == S_IDLE && start_i) begin
			send_sr <= {cmd_index_i, cmd_arg_i};
			crc <= '0;
		end else if (bit_tick_i) begin
			case (state)
				S_START: crc <= crc7_next(crc, 1'b0);
				S_HOST:  crc <= crc7_next(crc, 1'b1);
				S_BODY: begin
					crc <= crc7_next(crc, send_sr[BODY_W-1]);
					send_sr <= {send_sr[BODY_W-2:0], 1'b0};
				end
				S_CRC: crc <= {crc[CRC7_W-2:0], 1'b0};
				S_RSP_START: begin
					if (!cmd_in_i)
						crc <= crc7_next(crc, 1'b0);
				end
				S_RSP_BODY: crc <= crc7_next(crc, cmd_in_i);
				default: ;
			endcase
		end
	end

endmodule

// ==== rtl/sd_cmd_regs.sv ====
// bus slave with single-cycle ack; read data is valid only while ACK_O is high
`timescale 1ns/1ps

module sd_cmd_regs (
	input  logic                                  CLK_I,
	input  logic                                  RST_I,
	input  logic                                  CYC_I,
	input  logic                                  STB_I,
	input  logic                                  WE_I,
	input  logic [sd_bus_pkg::BUS_ADDR_W-1:0]     ADR_I,
	input  logic [sd_bus_pkg::BUS_DATA_W/8-1:0]   SEL_I,
	input  logic [sd_bus_pkg::BUS_DATA_W-1:0]     slave_dat_i,
	input  logic                                  busy_i,
	input  logic [1:0]                            err_code_i,
	input  sd_proto_pkg::sd_reply_t               reply_i,
	output logic                                  ACK_O,
	output logic [sd_bus_pkg::BUS_DATA_W-1:0]     slave_dat_o,
	output logic                                  start_o,
	output logic [sd_proto_pkg::CMD_INDEX_W-1:0]  cmd_index_o,
	output logic [sd_proto_pkg::CMD_ARG_W-1:0]    cmd_arg_o,
	output logic [1:0]                            reply_kind_o
);
	import sd_bus_pkg::*;
	import sd_proto_pkg::*;

	logic                  wr_req;
	logic [BUS_DATA_W-1:0] arg_q;
	logic [BUS_DATA_W-1:0] cmd_word;
	logic [BUS_DATA_W-1:0] stat_word;

	// a request counts once, in the cycle before its ack
	assign wr_req = CYC_I && STB_I && !ACK_O && WE_I;
	assign cmd_arg_o = arg_q;

	always_ff @(posedge CLK_I) begin
		if (RST_I) begin
			ACK_O <= 1'b0;
			start_o <= 1'b0;
			cmd_index_o <= '0;
			reply_kind_o <= REPLY_KIND_NONE;
		end else begin
			ACK_O <= CYC_I && STB_I && !ACK_O;
			// every command write fires, even with no byte enabled
			start_o <= wr_req && (ADR_I == REG_CMD);
			if (wr_req && (ADR_I == REG_CMD)) begin
				if (SEL_I[CMD_INDEX_LSB/8])
					cmd_index_o <= slave_dat_i[CMD_INDEX_LSB +: CMD_INDEX_W];
				if (SEL_I[CMD_KIND_LSB/8])
					reply_kind_o <= slave_dat_i[CMD_KIND_LSB +: 2];
			end
		end
	end

	// argument, byte by byte
	always_ff @(posedge CLK_I) begin
		if (wr_req && (ADR_I == REG_ARG)) begin
			for (int b = 0; b < BUS_DATA_W/8; b++) begin
				if (SEL_I[b])
					arg_q[8*b +: 8] <= slave_dat_i[8*b +: 8];
			end
		end
	end

	always_comb begin
		cmd_word = '0;
		cmd_word[CMD_INDEX_LSB +: CMD_INDEX_W] = cmd_index_o;
		cmd_word[CMD_KIND_LSB +: 2] = reply_kind_o;

		stat_word = '0;
		stat_word[STAT_BUSY_BIT] = busy_i;
		stat_word[STAT_ERR_LSB +: 2] = err_code_i;
		stat_word[STAT_INDEX_LSB +: CMD_INDEX_W] = reply_i.r1.index;
	end

	// payload sits at the same bits in R1 and R3
	always_comb begin
		case (ADR_I)
			REG_ARG:    slave_dat_o = arg_q;
			REG_CMD:    slave_dat_o = cmd_word;
			REG_STATUS: slave_dat_o = stat_word;
			default:    slave_dat_o = reply_i.r1.card_status;
		endcase
	end

endmodule

// ==== rtl/sd_cmd_top.sv ====
// command line only; needs an external pull-up on sd_cmd_io, no data lines
`timescale 1ns/1ps

module sd_cmd_top (
	input  logic                              CLK_I,
	input  logic                              RST_I,
	input  logic                              CYC_I,
	input  logic                              STB_I,
	input  logic                              WE_I,
	input  logic [sd_bus_pkg::BUS_ADDR_W-1:0]   ADR_I,
	input  logic [sd_bus_pkg::BUS_DATA_W/8-1:0] SEL_I,
	input  logic [sd_bus_pkg::BUS_DATA_W-1:0]   slave_dat_i,
	output logic                              ACK_O,
	output logic [sd_bus_pkg::BUS_DATA_W-1:0]   slave_dat_o,
	output logic                              sd_clk_o,
	inout  wire                               sd_cmd_io
);
	import sd_proto_pkg::*;

	logic                   start;
	logic [CMD_INDEX_W-1:0] cmd_index;
	logic [CMD_ARG_W-1:0]   cmd_arg;
	logic [1:0]             reply_kind;
	logic                   busy;
	logic [1:0]             err_code;
	sd_reply_t              reply;
	logic                   clk_ena;
	logic                   bit_tick;
	logic                   cmd_out;
	logic                   cmd_oe;

	// released line floats high through the card pull-up
	assign sd_cmd_io = cmd_oe ? cmd_out : 1'bz;

	sd_cmd_regs regs_i (
		.CLK_I(CLK_I), .RST_I(RST_I),
		.CYC_I(CYC_I), .STB_I(STB_I), .WE_I(WE_I), .ADR_I(ADR_I), .SEL_I(SEL_I),
		.slave_dat_i(slave_dat_i), .busy_i(busy), .err_code_i(err_code), .reply_i(reply),
		.ACK_O(ACK_O), .slave_dat_o(slave_dat_o), .start_o(start),
		.cmd_index_o(cmd_index), .cmd_arg_o(cmd_arg), .reply_kind_o(reply_kind)
	);

	sd_clk_gen clk_gen_i (
		.CLK_I(CLK_I), .RST_I(RST_I), .clk_ena_i(clk_ena),
		.sd_clk_o(sd_clk_o), .bit_tick_o(bit_tick)
	);

	sd_cmd_engine engine_i (
		.CLK_I(CLK_I), .RST_I(RST_I), .start_i(start),
		.cmd_index_i(cmd_index), .cmd_arg_i(cmd_arg), .reply_kind_i(reply_kind),
		.bit_tick_i(bit_tick), .cmd_in_i(sd_cmd_io),
		.cmd_out_o(cmd_out), .cmd_oe_o(cmd_oe), .clk_ena_o(clk_ena),
		.busy_o(busy), .err_code_o(err_code), .reply_o(reply)
	);

endmodule

// ==== rtl/sd_proto_pkg.sv ====
// SD command line protocol, 48-bit frames only; R2 and busy replies are not described here
package sd_proto_pkg;

	// frame geometry
	localparam int CMD_INDEX_W = 6;
	localparam int CMD_ARG_W   = 32;
	localparam int CMD_FRAME_W = 48;
	localparam int CRC7_W      = 7;

	// idle ones around a command, in SD clocks
	localparam int PREAMBLE_BITS  = 8;
	localparam int POSTAMBLE_BITS = 8;

	// SD clocks waited for the reply start bit
	localparam int REPLY_TIMEOUT = 255;

	// reply kinds
	localparam logic [1:0] REPLY_KIND_NONE = 2'd0;
	localparam logic [1:0] REPLY_KIND_R1   = 2'd1;
	localparam logic [1:0] REPLY_KIND_R3   = 2'd2;

	// error codes
	localparam logic [1:0] ERR_NONE    = 2'd0;
	localparam logic [1:0] ERR_TIMEOUT = 2'd1;
	localparam logic [1:0] ERR_CRC     = 2'd2;
	localparam logic [1:0] ERR_END_BIT = 2'd3;

	// one reply word, seen either as R1 or as R3 (OCR)
	typedef union packed {
		struct packed {
			logic                   start_bit;
			logic                   dir;
			logic [CMD_INDEX_W-1:0] index;
			logic [CMD_ARG_W-1:0]   card_status;
			logic [CRC7_W-1:0]      crc;
			logic                   end_bit;
		} r1;
		struct packed {
			logic                   start_bit;
			logic                   dir;
			logic [CMD_INDEX_W-1:0] rsvd_hi;
			logic [CMD_ARG_W-1:0]   ocr;
			logic [CRC7_W-1:0]      rsvd_lo;
			logic                   end_bit;
		} r3;
	} sd_reply_t;

endpackage

// ==== sd_cmd.f ====
rtl/sd_bus_pkg.sv
rtl/sd_proto_pkg.sv
rtl/sd_cmd_regs.sv
rtl/sd_clk_gen.sv
rtl/sd_cmd_engine.sv
rtl/sd_cmd_top.sv
verification/tb_clock.sv
verification/sd_cmd_chk.sv
verification/sd_cmd_tb.sv

// ==== verification/sd_cmd_chk.sv ====
// bound into sd_cmd_top; ack and clock checks are off during reset
`timescale 1ns/1ps

module sd_cmd_chk (
	input logic CLK_I,
	input logic RST_I,
	input logic ack_i,
	input logic sd_clk_i,
	input logic busy_i,
	input logic cmd_oe_i
);

	int assert_fails = 0;

	ack_one_cycle: assert property (@(posedge CLK_I) disable iff (RST_I) ack_i |=> !ack_i)
		else begin
			$error("ACK_O was high on two cycles in a row");
			assert_fails++;
		end

	// card clock only runs inside a command
	clk_stopped_idle: assert property (@(posedge CLK_I) disable iff (RST_I) !busy_i |-> !sd_clk_i)
		else begin
			$error("sd_clk_o toggled while the engine was idle");
			assert_fails++;
		end

	oe_low_after_reset: assert property (@(posedge CLK_I) RST_I |=> !cmd_oe_i)
		else begin
			$error("command line driven right after reset");
			assert_fails++;
		end

endmodule

bind sd_cmd_top sd_cmd_chk chk_i (
	.CLK_I(CLK_I), .RST_I(RST_I), .ack_i(ACK_O), .sd_clk_i(sd_clk_o),
	.busy_i(busy), .cmd_oe_i(cmd_oe)
);

// ==== verification/sd_cmd_golden.txt ====
# name index arg kind(0 none,1 r1,2 r3) answers delay payload corrupt(0 none,1 crc,2 end) err
# all hex except delay, which is decimal SD clocks after the end bit
cmd0_go_idle       00 00000000 0 0 0  00000000 0 0
cmd8_if_cond       08 000001aa 1 1 2  000001aa 0 0
cmd55_app_cmd      37 00000000 1 1 5  00000120 0 0
acmd41_ocr         29 40ff8000 2 1 3  80ff8000 0 0
acmd41_rsvd_flip   29 40ff8000 2 1 6  c0ff8000 1 0
cmd16_bad_crc      10 00000200 1 1 4  00000900 1 2
cmd17_bad_end      11 00001000 1 1 1  00000900 2 3
cmd5_no_card       05 00000000 1 0 0  00000000 0 1
cmd13_recover      0d 12340000 1 1 40 00000700 0 0
acmd41_bad_end     29 00000000 2 1 7  00ff8000 2 3

// ==== verification/sd_cmd_tb.sv ====
// reads verification/sd_cmd_golden.txt relative to the project root; card replies need delay >= 1
`timescale 1ns/1ps

module sd_cmd_tb;
	import sd_bus_pkg::*;
	import sd_proto_pkg::*;

	localparam int CYCLES_PER_TEST = 1600;
	localparam int RESET_CYCLES    = 4;

	logic                    CLK_I;
	logic                    RST_I;
	logic                    CYC_I;
	logic                    STB_I;
	logic                    WE_I;
	logic [BUS_ADDR_W-1:0]   ADR_I;
	logic [BUS_DATA_W/8-1:0] SEL_I;
	logic [BUS_DATA_W-1:0]   slave_dat_i;
	wire                     ACK_O;
	wire  [BUS_DATA_W-1:0]   slave_dat_o;
	wire                     sd_clk_o;
	wire                     sd_cmd_io;

	// card side of the command line
	logic card_oe;
	logic card_bit;
	logic pull_hi;

	// golden tests
	string      t_name[$];
	logic [5:0] t_index[$];
	logic [31:0] t_arg[$];
	logic [1:0] t_kind[$];
	logic       t_ans[$];
	int         t_delay[$];
	logic [31:0] t_payload[$];
	logic [1:0] t_corrupt[$];
	logic [1:0] t_err[$];

	// current test as the card model sees it
	string       cur_name;
	logic [1:0]  card_kind;
	logic        card_answers;
	int          card_delay;
	logic [31:0] card_payload;
	logic [1:0]  card_corrupt;
	logic [47:0] frame_seen;
	logic        frame_done;
	logic        cmd_finished;

	int frame_errs = 0;
	int status_errs = 0;
	int reply_errs = 0;
	int other_errs = 0;
	int cycle_cnt = 0;
	int cycle_limit = 0;

	tb_clock clock_i (.clk_o(CLK_I), .rst_o(RST_I));

	sd_cmd_top dut_i (
		.CLK_I(CLK_I), .RST_I(RST_I), .CYC_I(CYC_I), .STB_I(STB_I), .WE_I(WE_I),
		.ADR_I(ADR_I), .SEL_I(SEL_I), .slave_dat_i(slave_dat_i), .ACK_O(ACK_O),
		.slave_dat_o(slave_dat_o), .sd_clk_o(sd_clk_o), .sd_cmd_io(sd_cmd_io)
	);

	assign sd_cmd_io = card_oe ? card_bit : 1'bz;
	// weak pull-up; turned into a pull-down to spot a released line
	assign (pull0, pull1) sd_cmd_io = pull_hi;

	// x^7 + x^3 + 1 by long division over the first 40 frame bits
	function automatic logic [6:0] crc7_of(input logic [39:0] msg);
		logic [46:0] rem;
		rem = {msg, 7'b0};
		for (int i = 46; i >= 7; i--) begin
			if (rem[i])
				rem[i -: 8] = rem[i -: 8] ^ 8'h89;
		end
		return rem[6:0];
	endfunction

	function automatic sd_reply_t build_reply(input logic [5:0] idx);
		sd_reply_t rep;
		rep = '0;
		if (card_kind == REPLY_KIND_R3) begin
			rep.r3.rsvd_hi = '1;
			rep.r3.ocr = card_payload;
			rep.r3.rsvd_lo = '1;
		end else begin
			rep.r1.index = idx;
			rep.r1.card_status = card_payload;
			rep.r1.crc = crc7_of(rep[47:8]);
		end
		rep.r1.end_bit = 1'b1;
		if (card_corrupt == 2'd1)
			rep.r1.crc = rep.r1.crc ^ 7'h01;
		else if (card_corrupt == 2'd2)
			rep.r1.end_bit = 1'b0;
		return rep;
	endfunction

	// card drives after its falling clock edge
	task automatic send_reply(input sd_reply_t rep);
		repeat (card_delay) @(posedge sd_clk_o);
		for (int i = 47; i >= 0; i--) begin
			@(negedge sd_clk_o);
			@(negedge CLK_I);
			card_bit = rep[i];
			card_oe = 1'b1;
		end
		@(negedge sd_clk_o);
		@(negedge CLK_I);
		card_oe = 1'b0;
	endtask

	task automatic watch_held_line();
		@(negedge CLK_I);
		pull_hi = 1'b0;
		while (!cmd_finished) begin
			@(posedge sd_clk_o or posedge cmd_finished);
			if (!cmd_finished && sd_cmd_io !== 1'b1) begin
				$display("command line was released before busy fell in %s", cur_name);
				other_errs++;
			end
		end
		pull_hi = 1'b1;
	endtask

	initial begin : card_model
		logic [47:0] rx;
		forever begin
			do @(posedge sd_clk_o); while (sd_cmd_io !== 1'b0);
			rx[47] = 1'b0;
			for (int i = 46; i >= 0; i--) begin
				@(posedge sd_clk_o);
				rx[i] = sd_cmd_io;
			end
			frame_seen = rx;
			frame_done = 1'b1;
			if (card_kind == REPLY_KIND_NONE)
				watch_held_line();
			else if (card_answers)
				send_reply(build_reply(rx[45:40]));
		end
	end

	task automatic bus_write(input logic [BUS_ADDR_W-1:0] addr, input logic [BUS_DATA_W-1:0] data);
		@(negedge CLK_I);
		CYC_I = 1'b1;
		STB_I = 1'b1;
		WE_I = 1'b1;
		ADR_I = addr;
		SEL_I = '1;
		slave_dat_i = data;
		@(negedge CLK_I);
		while (!ACK_O) @(negedge CLK_I);
		CYC_I = 1'b0;
		STB_I = 1'b0;
		WE_I = 1'b0;
	endtask

	task automatic bus_read(input logic [BUS_ADDR_W-1:0] addr, output logic [BUS_DATA_W-1:0] data);
		@(negedge CLK_I);
		CYC_I = 1'b1;
		STB_I = 1'b1;
		WE_I = 1'b0;
		ADR_I = addr;
		@(negedge CLK_I);
		while (!ACK_O) @(negedge CLK_I);
		data = slave_dat_o;
		CYC_I = 1'b0;
		STB_I = 1'b0;
	endtask

	task automatic check_frame(input string name, input logic [47:0] exp, input logic [47:0] act);
		if (act !== exp) begin
			$display("Fail %s frame: expected %h, actual %h", name, exp, act);
			frame_errs++;
		end
	endtask

	task automatic check_status(input string name, input logic [1:0] exp_err,
			input logic [CMD_INDEX_W-1:0] exp_idx, input logic [1:0] act_err,
			input logic [CMD_INDEX_W-1:0] act_idx);
		if (act_err !== exp_err || act_idx !== exp_idx) begin
			$display("Fail %s status: expected err %0d index %h, actual err %0d index %h",
				name, exp_err, exp_idx, act_err, act_idx);
			status_errs++;
		end
	endtask

	task automatic check_reply(input string name, input sd_reply_t exp, input sd_reply_t act);
		if (act !== exp) begin
			$display("Fail %s reply: expected %h, actual %h", name, exp, act);
			reply_errs++;
		end
	endtask

	initial begin : watchdog
		wait (cycle_limit != 0);
		while (cycle_cnt < cycle_limit) begin
			@(posedge CLK_I);
			cycle_cnt++;
		end
		$display("the run timed out after %0d cycles", cycle_cnt);
		$display("Some tests failed");
		$finish;
	end

	initial begin : main
		int fd;
		int n;
		int dly;
		int total;
		string line;
		string nm;
		logic [31:0] f_idx;
		logic [31:0] f_arg;
		logic [31:0] f_kind;
		logic [31:0] f_ans;
		logic [31:0] f_pay;
		logic [31:0] f_cor;
		logic [31:0] f_err;
		logic [BUS_DATA_W-1:0] st;
		logic [BUS_DATA_W-1:0] rp;
		logic [BUS_DATA_W-1:0] w;
		logic [47:0] exp_frame;
		logic [CMD_INDEX_W-1:0] exp_idx;
		sd_reply_t exp_rep;
		sd_reply_t act_rep;

		CYC_I = 1'b0;
		STB_I = 1'b0;
		WE_I = 1'b0;
		ADR_I = '0;
		SEL_I = '0;
		slave_dat_i = '0;
		card_oe = 1'b0;
		card_bit = 1'b1;
		pull_hi = 1'b1;
		card_kind = REPLY_KIND_NONE;
		card_answers = 1'b0;
		frame_done = 1'b0;
		cmd_finished = 1'b0;

		fd = $fopen("verification/sd_cmd_golden.txt", "r");
		if (fd == 0) begin
			$display("could not open the golden file");
			other_errs++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
					n = $sscanf(line, "%s %h %h %h %h %d %h %h %h", nm, f_idx, f_arg,
						f_kind, f_ans, dly, f_pay, f_cor, f_err);
					if (n == 9) begin
						t_name.push_back(nm);
						t_index.push_back(f_idx[5:0]);
						t_arg.push_back(f_arg);
						t_kind.push_back(f_kind[1:0]);
						t_ans.push_back(f_ans[0]);
						t_delay.push_back(dly);
						t_payload.push_back(f_pay);
						t_corrupt.push_back(f_cor[1:0]);
						t_err.push_back(f_err[1:0]);
					end
				end
			end
			$fclose(fd);
		end
		if (t_name.size() == 0) begin
			$display("the golden file holds no tests");
			other_errs++;
		end
		cycle_limit = RESET_CYCLES + CYCLES_PER_TEST * (t_name.size() > 0 ? t_name.size() : 1);

		while (RST_I !== 1'b0) @(negedge CLK_I);

		for (int t = 0; t < t_name.size(); t++) begin
			cur_name = t_name[t];
			card_kind = t_kind[t];
			card_answers = t_ans[t];
			card_delay = t_delay[t];
			card_payload = t_payload[t];
			card_corrupt = t_corrupt[t];
			frame_done = 1'b0;
			cmd_finished = 1'b0;

			w = '0;
			w[CMD_INDEX_LSB +: CMD_INDEX_W] = t_index[t];
			w[CMD_KIND_LSB +: 2] = t_kind[t];
			bus_write(REG_ARG, t_arg[t]);
			bus_write(REG_CMD, w);

			// busy is already up when the first poll is sampled
			st = '1;
			while (st[STAT_BUSY_BIT])
				bus_read(REG_STATUS, st);
			cmd_finished = 1'b1;
			bus_read(REG_REPLY, rp);

			exp_frame = {2'b01, t_index[t], t_arg[t],
				crc7_of({2'b01, t_index[t], t_arg[t]}), 1'b1};
			if (frame_done)
				check_frame(cur_name, exp_frame, frame_seen);
			else begin
				$display("no command frame was seen on the line in %s", cur_name);
				other_errs++;
			end

			exp_rep = '0;
			exp_idx = '0;
			if (t_ans[t] && t_kind[t] == REPLY_KIND_R3) begin
				exp_idx = '1;
				exp_rep.r3.ocr = t_payload[t];
			end else if (t_ans[t] && t_kind[t] == REPLY_KIND_R1) begin
				exp_idx = t_index[t];
				exp_rep.r1.card_status = t_payload[t];
			end
			act_rep = '0;
			act_rep.r1.card_status = rp;
			check_status(cur_name, t_err[t], exp_idx, st[STAT_ERR_LSB +: 2],
				st[STAT_INDEX_LSB +: CMD_INDEX_W]);
			check_reply(cur_name, exp_rep, act_rep);
		end

		total = frame_errs + status_errs + reply_errs + other_errs + dut_i.chk_i.assert_fails;
		$display("errors: frame %0d, status %0d, reply %0d, other %0d, assertion %0d",
			frame_errs, status_errs, reply_errs, other_errs, dut_i.chk_i.assert_fails);
		if (total == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

// ==== verification/tb_clock.sv ====
// free-running 100 ns clock, reset held high over the first 4 rising edges
`timescale 1ns/1ps

module tb_clock (
	output logic clk_o,
	output logic rst_o
);
	localparam int HALF_PERIOD  = 50;
	localparam int RESET_CYCLES = 4;

	initial begin
		clk_o = 1'b0;
		forever #HALF_PERIOD clk_o = ~clk_o;
	end

	// release on a falling edge, away from the sampling edge
	initial begin
		rst_o = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_o);
		@(negedge clk_o);
		rst_o = 1'b0;
	end

endmodule
